//--- hw/lsu_pkg.sv
// load/store unit shared types

package lsu_pkg;

  // memory geometry
  localparam int SRAM_AW    = 8;
  localparam int SRAM_DEPTH = 1 << SRAM_AW;

  typedef logic [31:0]        word_t;
  typedef logic [3:0]         strb_t;
  typedef logic [2:0]         func_t;
  typedef logic [1:0]         byte_off_t;
  typedef logic [SRAM_AW-1:0] mem_idx_t;

  // funct3 encodings
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_func_e;

  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } store_func_e;

  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W
  } load_size_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA,
    RD_RESP
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_REQ,
    WR_BRESP,
    WR_RESP
  } wr_state_e;

endpackage

//--- hw/axi_lite_if.sv
// bus and load result interfaces
`timescale 1ns/1ps

interface axi_r_if;
  lsu_pkg::word_t araddr;
  logic           arvalid;
  logic           arready;
  lsu_pkg::word_t rdata;
  logic           rvalid;
  logic           rready;

  modport master (output araddr, arvalid, rready, input arready, rdata, rvalid);
  modport slave  (input araddr, arvalid, rready, output arready, rdata, rvalid);
endinterface

interface axi_w_if;
  lsu_pkg::word_t awaddr;
  logic           awvalid;
  logic           awready;
  lsu_pkg::word_t wdata;
  lsu_pkg::strb_t wstrb;
  logic           wvalid;
  logic           wready;
  logic           bvalid;
  logic           bready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bvalid
  );
  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bvalid
  );
endinterface

// raw load word plus how to format it
interface ld_res_if;
  lsu_pkg::word_t      word;
  lsu_pkg::byte_off_t  off;
  lsu_pkg::load_size_e size;
  logic                sext;

  modport source (output word, off, size, sext);
  modport sink   (input word, off, size, sext);
endinterface

//--- hw/lsu_decode.sv
// request function decode
`timescale 1ns/1ps

module lsu_decode (
  input  lsu_pkg::word_t      raddr,
  input  lsu_pkg::func_t      rfunc,
  input  lsu_pkg::word_t      waddr,
  input  lsu_pkg::func_t      wfunc,
  input  lsu_pkg::word_t      wdata,
  output lsu_pkg::byte_off_t  ld_off,
  output lsu_pkg::load_size_e ld_size,
  output logic                ld_sext,
  output lsu_pkg::word_t      st_data,
  output lsu_pkg::strb_t      st_strb
);

  lsu_pkg::byte_off_t w_off;
  lsu_pkg::strb_t     st_mask;

  assign ld_off = raddr[1:0];
  assign w_off  = waddr[1:0];

  always_comb begin
    case (lsu_pkg::load_func_e'(rfunc))
      lsu_pkg::LD_BS: begin ld_size = lsu_pkg::SZ_B; ld_sext = 1'b1; end
      lsu_pkg::LD_BU: begin ld_size = lsu_pkg::SZ_B; ld_sext = 1'b0; end
      lsu_pkg::LD_HS: begin ld_size = lsu_pkg::SZ_H; ld_sext = 1'b1; end
      lsu_pkg::LD_HU: begin ld_size = lsu_pkg::SZ_H; ld_sext = 1'b0; end
      lsu_pkg::LD_W:  begin ld_size = lsu_pkg::SZ_W; ld_sext = 1'b0; end
      // unknown codes load a word
      default:        begin ld_size = lsu_pkg::SZ_W; ld_sext = 1'b0; end
    endcase
  end

  // mask before lane placement
  always_comb begin
    case (lsu_pkg::store_func_e'(wfunc))
      lsu_pkg::ST_B: st_mask = 4'b0001;
      lsu_pkg::ST_H: st_mask = 4'b0011;
      lsu_pkg::ST_W: st_mask = 4'b1111;
      default:       st_mask = 4'b1111;
    endcase
  end

  // lanes past byte 3 fall off the top
  assign st_strb = lsu_pkg::strb_t'(st_mask << w_off);
  assign st_data = wdata << {w_off, 3'b000};

endmodule

//--- hw/lsu_axi_master.sv
// read and write channel control
`timescale 1ns/1ps

module lsu_axi_master (
  input  logic                clk,
  input  logic                rstn,
  input  logic                rreq_valid,
  output logic                rreq_ready,
  input  lsu_pkg::word_t      raddr,
  input  lsu_pkg::byte_off_t  ld_off,
  input  lsu_pkg::load_size_e ld_size,
  input  logic                ld_sext,
  output logic                rres_valid,
  input  logic                rres_ready,
  input  logic                wreq_valid,
  output logic                wreq_ready,
  input  lsu_pkg::word_t      waddr,
  input  lsu_pkg::word_t      st_data,
  input  lsu_pkg::strb_t      st_strb,
  output logic                wres_valid,
  input  logic                wres_ready,
  axi_r_if.master             ram_r,
  axi_w_if.master             ram_w,
  ld_res_if.source            ld_res
);

  lsu_pkg::rd_state_e  rd_state;
  lsu_pkg::wr_state_e  wr_state;

  lsu_pkg::word_t      rd_addr_q;
  lsu_pkg::word_t      rd_word_q;
  lsu_pkg::byte_off_t  rd_off_q;
  lsu_pkg::load_size_e rd_size_q;
  logic                rd_sext_q;

  lsu_pkg::word_t      wr_addr_q;
  lsu_pkg::word_t      wr_data_q;
  lsu_pkg::strb_t      wr_strb_q;

  // read channel
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= lsu_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        lsu_pkg::RD_IDLE: if (rreq_valid) rd_state <= lsu_pkg::RD_ADDR;
        lsu_pkg::RD_ADDR: if (ram_r.arready) rd_state <= lsu_pkg::RD_DATA;
        lsu_pkg::RD_DATA: if (ram_r.rvalid) rd_state <= lsu_pkg::RD_RESP;
        lsu_pkg::RD_RESP: if (rres_ready) rd_state <= lsu_pkg::RD_IDLE;
        default:          rd_state <= lsu_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rreq_valid && rreq_ready) begin
      rd_addr_q <= {raddr[31:2], 2'b00};
      rd_off_q  <= ld_off;
      rd_size_q <= ld_size;
      rd_sext_q <= ld_sext;
    end
    // raw word, formatted downstream
    if (ram_r.rvalid && ram_r.rready) begin
      rd_word_q <= ram_r.rdata;
    end
  end

  assign rreq_ready    = (rd_state == lsu_pkg::RD_IDLE);
  assign rres_valid    = (rd_state == lsu_pkg::RD_RESP);
  assign ram_r.arvalid = (rd_state == lsu_pkg::RD_ADDR);
  assign ram_r.araddr  = rd_addr_q;
  assign ram_r.rready  = (rd_state == lsu_pkg::RD_DATA);

  assign ld_res.word = rd_word_q;
  assign ld_res.off  = rd_off_q;
  assign ld_res.size = rd_size_q;
  assign ld_res.sext = rd_sext_q;

  // write channel, AW and W issued together
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= lsu_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        lsu_pkg::WR_IDLE: if (wreq_valid) wr_state <= lsu_pkg::WR_REQ;
        lsu_pkg::WR_REQ: begin
          if (ram_w.awready && ram_w.wready) wr_state <= lsu_pkg::WR_BRESP;
        end
        lsu_pkg::WR_BRESP: if (ram_w.bvalid) wr_state <= lsu_pkg::WR_RESP;
        lsu_pkg::WR_RESP:  if (wres_ready) wr_state <= lsu_pkg::WR_IDLE;
        default:           wr_state <= lsu_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wreq_valid && wreq_ready) begin
      wr_addr_q <= {waddr[31:2], 2'b00};
      wr_data_q <= st_data;
      wr_strb_q <= st_strb;
    end
  end

  assign wreq_ready    = (wr_state == lsu_pkg::WR_IDLE);
  assign wres_valid    = (wr_state == lsu_pkg::WR_RESP);
  assign ram_w.awvalid = (wr_state == lsu_pkg::WR_REQ);
  assign ram_w.wvalid  = (wr_state == lsu_pkg::WR_REQ);
  assign ram_w.awaddr  = wr_addr_q;
  assign ram_w.wdata   = wr_data_q;
  assign ram_w.wstrb   = wr_strb_q;
  assign ram_w.bready  = (wr_state == lsu_pkg::WR_BRESP);

endmodule

//--- hw/lsu_load_format.sv
// load result formatting
`timescale 1ns/1ps

module lsu_load_format (
  ld_res_if.sink         ld_res,
  output lsu_pkg::word_t rdata
);

  lsu_pkg::word_t shifted;

  // addressed byte down to lane 0
  assign shifted = ld_res.word >> {ld_res.off, 3'b000};

  always_comb begin
    case (ld_res.size)
      lsu_pkg::SZ_B: begin
        rdata = {{24{ld_res.sext & shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::SZ_H: begin
        // upper byte already zero when the halfword crosses the word end
        rdata = {{16{ld_res.sext & shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::SZ_W: rdata = shifted;
      default:       rdata = shifted;
    endcase
  end

endmodule

//--- hw/axi_lite_sram.sv
// word memory with bus slave ports
`timescale 1ns/1ps

module axi_lite_sram (
  input  logic   clk,
  input  logic   rstn,
  axi_r_if.slave ram_r,
  axi_w_if.slave ram_w
);

  lsu_pkg::word_t   mem [lsu_pkg::SRAM_DEPTH];
  lsu_pkg::mem_idx_t rd_idx;
  lsu_pkg::mem_idx_t wr_idx;
  lsu_pkg::word_t   rdata_q;
  logic             rvalid_q;
  logic             bvalid_q;
  logic             wr_take;

  // upper address bits ignored
  assign rd_idx = ram_r.araddr[lsu_pkg::SRAM_AW+1:2];
  assign wr_idx = ram_w.awaddr[lsu_pkg::SRAM_AW+1:2];

  // idle when no response pending
  assign ram_r.arready = !rvalid_q;
  assign ram_w.awready = !bvalid_q;
  assign ram_w.wready  = !bvalid_q;

  assign wr_take = ram_w.awvalid && ram_w.wvalid && !bvalid_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (ram_r.arvalid && ram_r.arready) begin
        rvalid_q <= 1'b1;
      end else if (ram_r.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_take) begin
        bvalid_q <= 1'b1;
      end else if (ram_w.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ram_r.arvalid && ram_r.arready) begin
      rdata_q <= mem[rd_idx];
    end
    if (wr_take) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_w.wstrb[i]) mem[wr_idx][8*i +: 8] <= ram_w.wdata[8*i +: 8];
      end
    end
  end

  assign ram_r.rdata  = rdata_q;
  assign ram_r.rvalid = rvalid_q;
  assign ram_w.bvalid = bvalid_q;

endmodule

//--- hw/lsu_top.sv
// load/store unit top level
`timescale 1ns/1ps

module lsu_top (
  input  logic           clk,
  input  logic           rstn,
  input  logic           rreq_valid,
  output logic           rreq_ready,
  input  lsu_pkg::word_t raddr,
  input  lsu_pkg::func_t rfunc,
  output logic           rres_valid,
  input  logic           rres_ready,
  output lsu_pkg::word_t rdata,
  input  logic           wreq_valid,
  output logic           wreq_ready,
  input  lsu_pkg::word_t waddr,
  input  lsu_pkg::func_t wfunc,
  input  lsu_pkg::word_t wdata,
  output logic           wres_valid,
  input  logic           wres_ready
);

  lsu_pkg::byte_off_t  ld_off;
  lsu_pkg::load_size_e ld_size;
  logic                ld_sext;
  lsu_pkg::word_t      st_data;
  lsu_pkg::strb_t      st_strb;

  axi_r_if  ram_r ();
  axi_w_if  ram_w ();
  ld_res_if ld_res ();

  lsu_decode decode_i (
    .raddr   (raddr),
    .rfunc   (rfunc),
    .waddr   (waddr),
    .wfunc   (wfunc),
    .wdata   (wdata),
    .ld_off  (ld_off),
    .ld_size (ld_size),
    .ld_sext (ld_sext),
    .st_data (st_data),
    .st_strb (st_strb)
  );

  lsu_axi_master master_i (
    .clk        (clk),
    .rstn       (rstn),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .raddr      (raddr),
    .ld_off     (ld_off),
    .ld_size    (ld_size),
    .ld_sext    (ld_sext),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .waddr      (waddr),
    .st_data    (st_data),
    .st_strb    (st_strb),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .ram_r      (ram_r.master),
    .ram_w      (ram_w.master),
    .ld_res     (ld_res.source)
  );

  lsu_load_format format_i (
    .ld_res (ld_res.sink),
    .rdata  (rdata)
  );

  axi_lite_sram sram_i (
    .clk   (clk),
    .rstn  (rstn),
    .ram_r (ram_r.slave),
    .ram_w (ram_w.slave)
  );

endmodule

//--- dv/lsu_assert.sv
// core channel protocol checks
`timescale 1ns/1ps

module lsu_assert (
  input logic           clk,
  input logic           rstn,
  input logic           rreq_valid,
  input logic           rreq_ready,
  input lsu_pkg::word_t raddr,
  input lsu_pkg::func_t rfunc,
  input logic           rres_valid,
  input logic           rres_ready,
  input lsu_pkg::word_t rdata,
  input logic           wreq_valid,
  input logic           wreq_ready,
  input lsu_pkg::word_t waddr,
  input lsu_pkg::func_t wfunc,
  input lsu_pkg::word_t wdata,
  input logic           wres_valid,
  input logic           wres_ready
);

  // valid and payload hold until taken
  rreq_hold: assert property (@(posedge clk) disable iff (!rstn)
    rreq_valid && !rreq_ready |=> rreq_valid && $stable({raddr, rfunc}))
    else $error("read request dropped or changed before transfer");

  rres_hold: assert property (@(posedge clk) disable iff (!rstn)
    rres_valid && !rres_ready |=> rres_valid && $stable(rdata))
    else $error("read response dropped or changed before transfer");

  wreq_hold: assert property (@(posedge clk) disable iff (!rstn)
    wreq_valid && !wreq_ready |=> wreq_valid && $stable({waddr, wfunc, wdata}))
    else $error("write request dropped or changed before transfer");

  wres_hold: assert property (@(posedge clk) disable iff (!rstn)
    wres_valid && !wres_ready |=> wres_valid)
    else $error("write response dropped before transfer");

  // one item per channel
  rd_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(rreq_ready && rres_valid))
    else $error("rreq_ready high while a read response is pending");

  wr_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(wreq_ready && wres_valid))
    else $error("wreq_ready high while a write response is pending");

endmodule

bind lsu_top lsu_assert assert_i (.*);

//--- dv/lsu_tb.sv
// load/store unit testbench
`timescale 1ns/1ps

module lsu_tb;

  localparam int N_WORDS = 16;
  localparam int N_SUB   = 8 + 5 * 4 * 8;
  localparam int N_BP    = 24;
  localparam int N_RAND  = 200;
  localparam int N_OPS   = 2 * N_WORDS + N_SUB + 2 * N_BP + N_RAND;

  logic           clk;
  logic           rstn;
  logic           rreq_valid;
  logic           rreq_ready;
  lsu_pkg::word_t raddr;
  lsu_pkg::func_t rfunc;
  logic           rres_valid;
  logic           rres_ready;
  lsu_pkg::word_t rdata;
  logic           wreq_valid;
  logic           wreq_ready;
  lsu_pkg::word_t waddr;
  lsu_pkg::func_t wfunc;
  lsu_pkg::word_t wdata;
  logic           wres_valid;
  logic           wres_ready;

  integer         seed = 32'h9df8_96b8;
  // byte image of the memory
  logic [7:0]     shadow [4 * lsu_pkg::SRAM_DEPTH];
  lsu_pkg::word_t exp_q [$];
  string          name_q [$];
  logic           held = 1'b0;
  lsu_pkg::word_t held_data;

  lsu_top dut_i (
    .clk        (clk),
    .rstn       (rstn),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .rdata      (rdata),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .waddr      (waddr),
    .wfunc      (wfunc),
    .wdata      (wdata),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_word(input string name, input lsu_pkg::word_t exp,
                            input lsu_pkg::word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // expected load result from the byte image
  function automatic lsu_pkg::word_t load_ref(input lsu_pkg::word_t addr,
                                              input lsu_pkg::func_t func);
    int             size;
    int             base;
    int             off;
    lsu_pkg::word_t res;
    base = 4 * int'(addr[lsu_pkg::SRAM_AW+1:2]);
    off  = int'(addr[1:0]);
    case (func)
      lsu_pkg::LD_BS, lsu_pkg::LD_BU: size = 1;
      lsu_pkg::LD_HS, lsu_pkg::LD_HU: size = 2;
      default:                        size = 4;
    endcase
    res = '0;
    for (int i = 0; i < size; i++) begin
      // bytes past the word end read as zero
      if (off + i < 4) res[8*i +: 8] = shadow[base + off + i];
    end
    if (func == lsu_pkg::LD_BS && res[7]) res[31:8] = '1;
    if (func == lsu_pkg::LD_HS && res[15]) res[31:16] = '1;
    return res;
  endfunction

  task automatic shadow_store(input lsu_pkg::word_t addr, input lsu_pkg::func_t func,
                              input lsu_pkg::word_t data);
    int size;
    int base;
    int off;
    base = 4 * int'(addr[lsu_pkg::SRAM_AW+1:2]);
    off  = int'(addr[1:0]);
    case (func)
      lsu_pkg::ST_B: size = 1;
      lsu_pkg::ST_H: size = 2;
      default:       size = 4;
    endcase
    for (int i = 0; i < size; i++) begin
      if (off + i < 4) shadow[base + off + i] = data[8*i +: 8];
    end
  endtask

  // random upper bits still land in words 0 to 15
  function automatic lsu_pkg::word_t rand_addr();
    return $random(seed) & 32'hffff_fc3f;
  endfunction

  task automatic load_op(input string name, input lsu_pkg::word_t addr,
                         input lsu_pkg::func_t func, input bit stall);
    int n;
    int hold;
    exp_q.push_back(load_ref(addr, func));
    name_q.push_back($sformatf("%s %h func %0d", name, addr, func));
    hold = stall ? 1 + ($random(seed) & 7) : 0;
    rreq_valid <= 1'b1;
    raddr      <= addr;
    rfunc      <= func;
    rres_ready <= !stall;
    do @(posedge clk); while (!rreq_ready);
    rreq_valid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (rres_valid && !rres_ready) begin
        hold--;
        if (hold == 0) rres_ready <= 1'b1;
      end
    end while (!(rres_valid && rres_ready));
    if (!stall) check_cycles({name, " latency"}, 3, n);
  endtask

  task automatic store_op(input string name, input lsu_pkg::word_t addr,
                          input lsu_pkg::func_t func, input lsu_pkg::word_t data,
                          input bit stall);
    int n;
    int hold;
    hold = stall ? 1 + ($random(seed) & 7) : 0;
    wreq_valid <= 1'b1;
    waddr      <= addr;
    wfunc      <= func;
    wdata      <= data;
    wres_ready <= !stall;
    do @(posedge clk); while (!wreq_ready);
    wreq_valid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (wres_valid && !wres_ready) begin
        check_cycles({name, " wreq_ready under back-pressure"}, 0, int'(wreq_ready));
        hold--;
        if (hold == 0) wres_ready <= 1'b1;
      end
    end while (!(wres_valid && wres_ready));
    shadow_store(addr, func, data);
    if (!stall) check_cycles({name, " latency"}, 3, n);
  endtask

  // read response compare
  always @(posedge clk) begin
    if (rstn && rres_valid) begin
      check_cycles("rreq_ready with response pending", 0, int'(rreq_ready));
      if (held) begin
        check_word("rdata under back-pressure", held_data, rdata);
      end
      if (rres_ready) begin
        held = 1'b0;
        if (exp_q.size() == 0) begin
          $display("read response arrived with no load outstanding");
          abort_run();
        end else begin
          check_word(name_q.pop_front(), exp_q.pop_front(), rdata);
        end
      end else begin
        held      = 1'b1;
        held_data = rdata;
      end
    end
  end

  initial begin
    repeat (N_OPS * 20 + 200) @(posedge clk);
    $display("watchdog expired before all %0d operations completed", N_OPS);
    abort_run();
  end

  initial begin
    lsu_pkg::word_t r;
    lsu_pkg::word_t ra;
    lsu_pkg::word_t wa;
    lsu_pkg::word_t wd;
    lsu_pkg::func_t rf;
    lsu_pkg::func_t wf;
    rstn       <= 1'b0;
    rreq_valid <= 1'b0;
    raddr      <= '0;
    rfunc      <= '0;
    rres_ready <= 1'b1;
    wreq_valid <= 1'b0;
    waddr      <= '0;
    wfunc      <= '0;
    wdata      <= '0;
    wres_ready <= 1'b1;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_cycles("reset rres_valid", 0, int'(rres_valid));
    check_cycles("reset wres_valid", 0, int'(wres_valid));
    check_cycles("reset rreq_ready", 1, int'(rreq_ready));
    check_cycles("reset wreq_ready", 1, int'(wreq_ready));

    for (int i = 0; i < N_WORDS; i++) begin
      r = $random(seed);
      store_op("word store", lsu_pkg::word_t'(4 * i), lsu_pkg::ST_W, r, 1'b0);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      load_op("word load", lsu_pkg::word_t'(4 * i), lsu_pkg::LD_W, 1'b0);
    end

    // bytes into word 4, halfwords into words 5 to 8
    for (int off = 0; off < 4; off++) begin
      r = $random(seed);
      store_op("byte store", lsu_pkg::word_t'(16 + off), lsu_pkg::ST_B, r, 1'b0);
      r = $random(seed);
      store_op("half store", lsu_pkg::word_t'(4 * (5 + off) + off), lsu_pkg::ST_H, r, 1'b0);
    end
    for (int w = 4; w <= 8; w++) begin
      for (int off = 0; off < 4; off++) begin
        for (int fc = 0; fc < 8; fc++) begin
          load_op("sub-word load", lsu_pkg::word_t'(4 * w + off), lsu_pkg::func_t'(fc), 1'b0);
        end
      end
    end

    for (int k = 0; k < N_BP; k++) begin
      r  = $random(seed);
      wf = r[2:0];
      wd = $random(seed);
      store_op("stalled store", rand_addr(), wf, wd, 1'b1);
      r  = $random(seed);
      rf = r[2:0];
      load_op("stalled load", rand_addr(), rf, 1'b1);
    end

    for (int k = 0; k < N_RAND / 2; k++) begin
      ra = rand_addr();
      wa = rand_addr();
      // keep both channels off the same word
      while (wa[5:2] == ra[5:2]) begin
        wa = rand_addr();
      end
      r  = $random(seed);
      rf = r[2:0];
      wf = r[6:4];
      wd = $random(seed);
      fork
        load_op("concurrent load", ra, rf, 1'b0);
        store_op("concurrent store", wa, wf, wd, 1'b0);
      join
    end

    // both channels back to idle with nothing left pending
    repeat (2) @(posedge clk);
    check_cycles("final rreq_ready", 1, int'(rreq_ready));
    check_cycles("final wreq_ready", 1, int'(wreq_ready));
    check_cycles("final rres_valid", 0, int'(rres_valid));
    check_cycles("final wres_valid", 0, int'(wres_valid));
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- files.f
hw/lsu_pkg.sv
hw/axi_lite_if.sv
hw/lsu_decode.sv
hw/lsu_axi_master.sv
hw/lsu_load_format.sv
hw/axi_lite_sram.sv
hw/lsu_top.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lsu_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation FAILED

.PHONY: sim clean

# a nonzero exit from the simulator also counts as failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
